//--- logic/fetch_pkg.sv
package fetch_pkg;

	// Instruction side widths
	typedef logic [31:0] pc_t;
	typedef logic [31:0] instruction_t;
	typedef logic [7:0] fetch_tag_t;
	typedef logic [6:0] opcode_t;

	// Record handed to the decoder, 72 bits
	typedef struct packed {
		fetch_tag_t tag;
		pc_t pc;
		instruction_t instruction;
	} fetch_record_t;

	typedef enum logic {
		fetch_running,
		fetch_wait_redirect
	} fetch_state_t;

	// RV32I major opcodes that change control flow
	localparam opcode_t opcode_jal = 7'b1101111;
	localparam opcode_t opcode_jalr = 7'b1100111;
	localparam opcode_t opcode_branch = 7'b1100011;
	localparam opcode_t opcode_system = 7'b1110011;

	// Full encodings, no operands
	localparam instruction_t instruction_mret = 32'h30200073;
	localparam instruction_t instruction_wfi = 32'h10500073;

	// Sequential advance, one word
	localparam pc_t pc_step = 32'd4;

endpackage

//--- logic/bus_pkg.sv
package bus_pkg;

	localparam int bus_width = 32;

	typedef logic [bus_width-1:0] bus_address_t;
	typedef logic [bus_width-1:0] bus_data_t;

	// Direct-mapped, one word per line
	localparam int cache_lines = 16;
	localparam int cache_offset_width = 2;
	localparam int cache_index_width = $clog2(cache_lines);
	localparam int cache_tag_low = cache_offset_width + cache_index_width;
	localparam int cache_tag_width = bus_width - cache_tag_low;

	// Index from address bits 5:2, tag from 31:6
	typedef logic [cache_index_width-1:0] cache_index_t;
	typedef logic [cache_tag_width-1:0] cache_tag_t;

endpackage

//--- logic/instruction_predecode.sv
`timescale 1ns/1ps

module instruction_predecode (
	input fetch_pkg::instruction_t i_instruction,
	output logic o_control_flow
);

	fetch_pkg::opcode_t opcode;
	logic is_jump;
	logic is_branch;
	logic is_system;
	logic is_mret;
	logic is_wfi;

	always_comb begin
		opcode = i_instruction[6:0];
	end

	// Direct and indirect unconditional jumps
	always_comb begin
		is_jump = (opcode == fetch_pkg::opcode_jal) ||
			(opcode == fetch_pkg::opcode_jalr);
	end

	always_comb begin
		is_branch = (opcode == fetch_pkg::opcode_branch);
	end

	// System opcode and the upper bits together form the full-word match
	always_comb begin
		is_system = (opcode == fetch_pkg::opcode_system);
		is_mret = is_system && (i_instruction[31:7] == fetch_pkg::instruction_mret[31:7]);
		is_wfi = is_system && (i_instruction[31:7] == fetch_pkg::instruction_wfi[31:7]);
	end

	// Fetch has to wait for a redirect after any of these
	always_comb begin
		o_control_flow = is_jump || is_branch || is_mret || is_wfi;
	end

endmodule

//--- logic/instruction_cache.sv
`timescale 1ns/1ps

module instruction_cache (
	input logic i_clock,
	input logic i_reset,

	// Lookup
	input fetch_pkg::pc_t i_pc,
	input logic i_stall,
	output logic o_ready,
	output fetch_pkg::instruction_t o_rdata,

	// Instruction bus
	output logic o_bus_request,
	input logic i_bus_ready,
	output bus_pkg::bus_address_t o_bus_address,
	input bus_pkg::bus_data_t i_bus_rdata
);

	typedef struct packed {
		bus_pkg::cache_tag_t tag;
		bus_pkg::bus_data_t data;
	} cache_line_t;

	cache_line_t lines [bus_pkg::cache_lines];
	logic [bus_pkg::cache_lines-1:0] line_valid;

	bus_pkg::cache_index_t lookup_index;
	bus_pkg::cache_tag_t lookup_tag;
	bus_pkg::cache_index_t fill_index;
	bus_pkg::cache_tag_t fill_tag;
	logic hit;
	logic fill_done;
	logic start_fill;

	// Split the presented pc
	always_comb begin
		lookup_index = i_pc[bus_pkg::cache_offset_width +: bus_pkg::cache_index_width];
		lookup_tag = i_pc[bus_pkg::cache_tag_low +: bus_pkg::cache_tag_width];
	end

	// Fill goes to the latched address, the pc may have moved on
	always_comb begin
		fill_index = o_bus_address[bus_pkg::cache_offset_width +: bus_pkg::cache_index_width];
		fill_tag = o_bus_address[bus_pkg::cache_tag_low +: bus_pkg::cache_tag_width];
	end

	// Hit path straight from the line registers
	always_comb begin
		hit = line_valid[lookup_index] && (lines[lookup_index].tag == lookup_tag);
		o_ready = hit;
		o_rdata = lines[lookup_index].data;
	end

	always_comb begin
		fill_done = o_bus_request && i_bus_ready;
		start_fill = !o_bus_request && !hit && !i_stall;
	end

	// Request level held until the ready strobe
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_bus_request <= 1'b0;
		end else if (fill_done) begin
			o_bus_request <= 1'b0;
		end else if (start_fill) begin
			o_bus_request <= 1'b1;
		end
	end

	// Word aligned miss address
	always_ff @(posedge i_clock) begin
		if (start_fill) begin
			o_bus_address <= {lookup_tag, lookup_index, {bus_pkg::cache_offset_width{1'b0}}};
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			line_valid <= '0;
		end else if (fill_done) begin
			line_valid[fill_index] <= 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (fill_done) begin
			lines[fill_index].tag <= fill_tag;
			lines[fill_index].data <= i_bus_rdata;
		end
	end

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input logic i_clock,
	input logic i_reset,

	// Redirect from later stages
	input logic i_jump,
	input fetch_pkg::pc_t i_jump_pc,

	// Interrupt
	input logic i_irq_pending,
	input fetch_pkg::pc_t i_irq_pc,
	output logic o_irq_dispatched,
	output fetch_pkg::pc_t o_irq_epc,

	// Instruction bus
	output logic o_bus_request,
	input logic i_bus_ready,
	output bus_pkg::bus_address_t o_bus_address,
	input bus_pkg::bus_data_t i_bus_rdata,

	// Decoder
	input logic i_decode_busy,
	output fetch_pkg::fetch_record_t o_data
);

	fetch_pkg::fetch_state_t state;
	fetch_pkg::pc_t pc;
	fetch_pkg::fetch_record_t record_current;
	fetch_pkg::fetch_record_t record_held;

	fetch_pkg::instruction_t cache_rdata;
	logic cache_ready;
	logic cache_stall;
	logic control_flow;
	logic deliver;

	instruction_cache instruction_cache_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(pc),
		.i_stall(cache_stall),
		.o_ready(cache_ready),
		.o_rdata(cache_rdata),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata)
	);

	instruction_predecode instruction_predecode_inst (
		.i_instruction(cache_rdata),
		.o_control_flow(control_flow)
	);

	// No new misses while decode is full or fetch is parked
	always_comb begin
		cache_stall = i_decode_busy || (state != fetch_pkg::fetch_running);
	end

	always_comb begin
		deliver = (state == fetch_pkg::fetch_running) && !i_decode_busy && cache_ready;
	end

	// Decoder sees the held copy while busy
	assign o_data = i_decode_busy ? record_held : record_current;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			record_held <= '0;
		end else if (!i_decode_busy) begin
			record_held <= record_current;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_pkg::fetch_running;
			pc <= '0;
			record_current <= '0;
			o_irq_dispatched <= 1'b0;
			o_irq_epc <= '0;
		end else begin
			o_irq_dispatched <= 1'b0;

			// Interrupt wins over everything and epc is the next pc to fetch
			if (i_irq_pending) begin
				o_irq_dispatched <= 1'b1;
				o_irq_epc <= pc;
				pc <= i_irq_pc;
				state <= fetch_pkg::fetch_running;
			end else begin
				case (state)
					fetch_pkg::fetch_running: begin
						if (deliver) begin
							record_current.tag <= record_current.tag + 8'd1;
							record_current.pc <= pc;
							record_current.instruction <= cache_rdata;

							// Target unknown here so park until redirected
							if (control_flow) begin
								state <= fetch_pkg::fetch_wait_redirect;
							end else begin
								pc <= pc + fetch_pkg::pc_step;
							end
						end
					end

					fetch_pkg::fetch_wait_redirect: begin
						if (i_jump) begin
							pc <= i_jump_pc;
							state <= fetch_pkg::fetch_running;
						end
					end

					default: begin
						state <= fetch_pkg::fetch_running;
					end
				endcase
			end
		end
	end

endmodule

//--- logic/fetch_subsystem.sv
`timescale 1ns/1ps

module fetch_subsystem (
	input logic i_clock,
	input logic i_reset,

	// Redirect
	input logic i_jump,
	input fetch_pkg::pc_t i_jump_pc,

	// Interrupt
	input logic i_irq_pending,
	input fetch_pkg::pc_t i_irq_pc,
	output logic o_irq_dispatched,
	output fetch_pkg::pc_t o_irq_epc,

	// Instruction bus
	output logic o_bus_request,
	input logic i_bus_ready,
	output bus_pkg::bus_address_t o_bus_address,
	input bus_pkg::bus_data_t i_bus_rdata,

	// Decoder
	input logic i_decode_busy,
	output fetch_pkg::fetch_record_t o_data
);

	fetch_unit fetch_unit_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata),
		.i_decode_busy(i_decode_busy),
		.o_data(o_data)
	);

endmodule

//--- testbench/fetch_subsystem_tb.sv
`timescale 1ns/1ps

module fetch_subsystem_tb;

	// About 150 records at under ~15 cycles each with a miss and a busy stretch
	localparam int cycle_limit = 20000;

	logic clock = 1'b0;
	logic reset;
	logic jump;
	fetch_pkg::pc_t jump_pc;
	logic irq_pending;
	fetch_pkg::pc_t irq_pc;
	logic irq_dispatched;
	fetch_pkg::pc_t irq_epc;
	logic bus_request;
	logic bus_ready;
	bus_pkg::bus_address_t bus_address;
	bus_pkg::bus_data_t bus_rdata;
	logic decode_busy;
	fetch_pkg::fetch_record_t fetch_data;

	// Stimulus side state
	logic [31:0] lfsr_state = 32'heb60;
	logic busy_enable;
	int busy_left;
	int latency_left;
	int bus_requests;
	bus_pkg::bus_address_t request_address;
	int cycle_count;

	// Reference model state owned by the checker
	fetch_pkg::fetch_tag_t last_tag;
	fetch_pkg::pc_t model_pc;
	fetch_pkg::pc_t expected_epc;
	fetch_pkg::fetch_record_t visible_record;
	logic waiting;
	logic irq_seen;
	int records_seen = 0;

	fetch_subsystem fetch_subsystem_inst (
		.i_clock(clock),
		.i_reset(reset),
		.i_jump(jump),
		.i_jump_pc(jump_pc),
		.i_irq_pending(irq_pending),
		.i_irq_pc(irq_pc),
		.o_irq_dispatched(irq_dispatched),
		.o_irq_epc(irq_epc),
		.o_bus_request(bus_request),
		.i_bus_ready(bus_ready),
		.o_bus_address(bus_address),
		.i_bus_rdata(bus_rdata),
		.i_decode_busy(decode_busy),
		.o_data(fetch_data)
	);

	always #4 clock = ~clock;

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic random_bits(input int count, output logic [31:0] value);
		int bit_index;
		value = '0;
		for (bit_index = 0; bit_index < count; bit_index++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	// Chosen addresses that hold control-flow words
	function automatic logic is_control_address(input logic [31:0] address);
		case (address)
			32'h040, 32'h120, 32'h2a0, 32'h3f0: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Memory contents as a hash of the address with an OP-IMM opcode
	function automatic logic [31:0] expected_word(input logic [31:0] address);
		logic [31:0] mixed;
		mixed = (address ^ 32'h5bd1e995) * 32'h9e3779b1;
		mixed = mixed ^ (mixed >> 15);
		case (address)
			32'h040: return 32'h0100006f;
			32'h120: return 32'h00208463;
			32'h2a0: return 32'h30200073;
			32'h3f0: return 32'h10500073;
			default: return {mixed[31:7], 7'b0010011};
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
			$display("tests failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Single-beat memory with 0 to 7 cycles of latency
	task automatic serve_bus();
		logic [31:0] bits;
		if (bus_ready) begin
			bus_ready = 1'b0;
			// Request has to drop right after the ready strobe
			check_value("o_bus_request", 32'(bus_request), 32'd0);
		end else if (bus_request) begin
			if (latency_left < 0) begin
				bus_requests++;
				request_address = bus_address;
				random_bits(3, bits);
				latency_left = int'(bits);
			end else begin
				check_value("o_bus_address", bus_address, request_address);
			end
			if (latency_left == 0) begin
				bus_ready = 1'b1;
				bus_rdata = expected_word(bus_address);
				latency_left = -1;
			end else begin
				latency_left--;
			end
		end
	endtask

	// Busy bursts of 1 to 8 cycles start one cycle in four
	task automatic drive_busy();
		logic [31:0] bits;
		if (!busy_enable) begin
			decode_busy = 1'b0;
		end else if (busy_left > 0) begin
			decode_busy = 1'b1;
			busy_left--;
		end else begin
			random_bits(2, bits);
			decode_busy = (bits == 32'd0);
			if (decode_busy) begin
				random_bits(3, bits);
				busy_left = int'(bits);
			end
		end
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#1;
		serve_bus();
		drive_busy();
	endtask

	task automatic redirect(input logic [31:0] target);
		jump = 1'b1;
		jump_pc = target;
		next_cycle();
		jump = 1'b0;
	endtask

	task automatic wait_for_stop();
		while (!waiting) begin
			next_cycle();
		end
	endtask

	task automatic wait_records(input int count);
		int target;
		target = records_seen + count;
		while (records_seen < target) begin
			next_cycle();
		end
	endtask

	task automatic raise_irq(input logic [31:0] handler);
		irq_pending = 1'b1;
		irq_pc = handler;
		next_cycle();
		while (!irq_dispatched) begin
			next_cycle();
		end
		irq_pending = 1'b0;
	endtask

	// Up to 7 words ahead of one of the control-flow addresses
	task automatic pick_target(output logic [31:0] target);
		logic [31:0] entry;
		logic [31:0] offset;
		random_bits(2, entry);
		random_bits(3, offset);
		case (entry)
			32'd0: target = 32'h040;
			32'd1: target = 32'h120;
			32'd2: target = 32'h2a0;
			default: target = 32'h3f0;
		endcase
		target = target - (offset << 2);
	endtask

	task automatic check_record();
		check_value("new tag while stopped", 32'(waiting), 32'd0);
		check_value("o_data.tag", 32'(fetch_data.tag), 32'(8'(last_tag + 8'd1)));
		check_value("o_data.pc", fetch_data.pc, model_pc);
		check_value("o_data.instruction", fetch_data.instruction, expected_word(model_pc));
		last_tag = fetch_data.tag;
		records_seen++;
		if (is_control_address(model_pc)) begin
			waiting = 1'b1;
		end else begin
			model_pc = model_pc + 32'd4;
		end
	endtask

	// Checker samples mid-cycle
	initial begin
		forever begin
			@(negedge clock);
			if (reset) begin
				last_tag = '0;
				model_pc = '0;
				waiting = 1'b0;
				irq_seen = 1'b0;
				visible_record = '0;
			end else begin
				check_value("o_irq_dispatched", 32'(irq_dispatched), 32'(irq_seen));
				if (irq_seen) begin
					check_value("o_irq_epc", irq_epc, expected_epc);
				end
				irq_seen = 1'b0;
				if (decode_busy) begin
					check_value("o_data.tag", 32'(fetch_data.tag), 32'(visible_record.tag));
					check_value("o_data.pc", fetch_data.pc, visible_record.pc);
					check_value("o_data.instruction", fetch_data.instruction,
						visible_record.instruction);
				end else begin
					visible_record = fetch_data;
					if (fetch_data.tag != last_tag) begin
						check_record();
					end
				end
				// Redirect only counts when stopped
				if (jump && waiting) begin
					model_pc = jump_pc;
					waiting = 1'b0;
				end
				if (irq_pending) begin
					irq_seen = 1'b1;
					expected_epc = model_pc;
					model_pc = irq_pc;
					waiting = 1'b0;
				end
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("tests failed");
		$fatal(1, "Timeout after %0d cycles without finishing the tests", cycle_limit);
	end

	initial begin
		fetch_pkg::fetch_tag_t held_tag;
		logic [31:0] target;
		int saved_requests;
		int pass;
		reset = 1'b1;
		jump = 1'b0;
		jump_pc = '0;
		irq_pending = 1'b0;
		irq_pc = '0;
		decode_busy = 1'b0;
		bus_ready = 1'b0;
		bus_rdata = '0;
		busy_enable = 1'b0;
		busy_left = 0;
		latency_left = -1;
		bus_requests = 0;
		request_address = '0;
		repeat (8) next_cycle();
		reset = 1'b0;

		// Sequential run up to the jal with an early pulse that must be ignored
		next_cycle();
		redirect(32'h800);
		wait_for_stop();
		held_tag = fetch_data.tag;
		repeat (6) next_cycle();
		check_value("o_data.tag", 32'(fetch_data.tag), 32'(held_tag));

		for (pass = 0; pass < 4; pass++) begin
			pick_target(target);
			redirect(target);
			wait_for_stop();
		end

		// Same again under decoder back-pressure
		busy_enable = 1'b1;
		for (pass = 0; pass < 6; pass++) begin
			pick_target(target);
			redirect(target);
			wait_for_stop();
		end
		busy_enable = 1'b0;
		next_cycle();

		// Loop body fetched twice with the second pass from the cache
		redirect(32'h100);
		wait_for_stop();
		saved_requests = bus_requests;
		redirect(32'h100);
		wait_for_stop();
		check_value("bus request count", bus_requests, saved_requests);

		// Interrupt while stopped and then while running
		raise_irq(32'h280);
		wait_for_stop();
		redirect(32'h3b4);
		wait_records(4);
		raise_irq(32'h0e0);
		wait_for_stop();

		$display("all tests passed");
		$finish;
	end

endmodule

//--- compile.f
logic/fetch_pkg.sv
logic/bus_pkg.sv
logic/instruction_predecode.sv
logic/instruction_cache.sv
logic/fetch_unit.sv
logic/fetch_subsystem.sv
testbench/fetch_subsystem_tb.sv

//--- Makefile
TOP := fetch_subsystem_tb

.PHONY: all run lint clean

all: run

# Build and run, the simulator exit status is the result
run:
	verilator --binary --timing -j 0 --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --top-module fetch_subsystem \
		logic/fetch_pkg.sv logic/bus_pkg.sv logic/instruction_predecode.sv \
		logic/instruction_cache.sv logic/fetch_unit.sv logic/fetch_subsystem.sv

clean:
	rm -rf obj_dir
